// ==== common/dualLanePkg.sv ====
`default_nettype none

package dualLanePkg;

    localparam int NumRegs   = 32;
    localparam int DataWords = 64;
    localparam int ImemWords = 64;
    localparam int XLen      = 32;

    // rv32i major opcodes used by the decoder
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    typedef logic [$clog2(NumRegs)-1:0]   regIdx;    // architectural register number
    typedef logic [XLen-1:0]              word;
    typedef logic [$clog2(ImemWords)-1:0] imemAddr;  // instruction word index
    typedef logic [$clog2(DataWords)-1:0] dmemAddr;  // data word index

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOp;
    typedef enum logic [1:0] {srcAlu, srcMem, srcPcPlus4} resultSrc;  // srcMem marks a load
    typedef enum logic [1:0] {pcSeq, pcBranch, pcJump} pcSel;         // non-seq is a redirect
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,  // value from writeback stage
        fwdMem  = 2'b10   // value from memory stage
    } forwardSel;

    typedef struct packed {
        regIdx    rs1;
        regIdx    rs2;
        regIdx    rd;
        word      imm;        // sign extended, format picked by opcode
        aluOp     aluCtl;
        resultSrc resSrc;
        logic     regWrite;
        logic     memWrite;
        logic     aluSrcImm;  // operand b from imm
        logic     isBranch;
        logic     isJump;
    } decodedOp;

    typedef struct packed {
        regIdx     rs1D;
        regIdx     rs2D;
        regIdx     rs1E;
        regIdx     rs2E;
        regIdx     rdE;
        regIdx     rdM;
        regIdx     rdW;
        logic      regWriteM;
        logic      regWriteW;
        resultSrc  resultSrcE;
        pcSel      pcSelE;
        logic      memWait;  // lost the data memory this cycle
    } laneHazardIn;

    typedef struct packed {
        forwardSel forwardA;
        forwardSel forwardB;
        logic      stallF;
        logic      stallD;
        logic      flushD;
        logic      flushE;
        logic      stallLane;  // freeze f..m, bubble into w
    } laneHazardCtrl;

    typedef struct packed {
        logic    valid;
        logic    write;
        dmemAddr addr;
        word     wdata;
    } memReq;

    typedef struct packed {
        logic  valid;
        regIdx rd;
        word   value;
    } retireInfo;

endpackage

`default_nettype wire

// ==== lane/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  dualLanePkg::word      instr,
    output dualLanePkg::decodedOp op
);
    import dualLanePkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word        immI, immS, immB, immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        op     = '0;            // unknown encodings retire nothing
        op.rs1 = instr[19:15];
        op.rs2 = instr[24:20];
        op.rd  = instr[11:7];
        case (opcode)
            OpReg: begin
                op.regWrite = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: op.aluCtl = aluAdd;
                    10'b0100000_000: op.aluCtl = aluSub;
                    10'b0000000_111: op.aluCtl = aluAnd;
                    10'b0000000_110: op.aluCtl = aluOr;
                    default:         op.regWrite = 1'b0;  // not one of the four
                endcase
            end
            OpImm: if (funct3 == 3'b000) begin  // addi only
                op.regWrite  = 1'b1;
                op.aluSrcImm = 1'b1;
                op.imm       = immI;
            end
            OpLoad: if (funct3 == 3'b010) begin  // lw, address = rs1 + imm
                op.regWrite  = 1'b1;
                op.aluSrcImm = 1'b1;
                op.resSrc    = srcMem;
                op.imm       = immI;
            end
            OpStore: if (funct3 == 3'b010) begin  // sw
                op.memWrite  = 1'b1;
                op.aluSrcImm = 1'b1;
                op.imm       = immS;
            end
            OpBranch: if (funct3 == 3'b000) begin  // beq
                op.isBranch = 1'b1;
                op.imm      = immB;
            end
            OpJal: begin
                op.regWrite = 1'b1;
                op.isJump   = 1'b1;
                op.resSrc   = srcPcPlus4;  // link value
                op.imm      = immJ;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== lane/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic               clk,
    input  logic               reset,
    input  dualLanePkg::regIdx raddr1,
    input  dualLanePkg::regIdx raddr2,
    input  dualLanePkg::regIdx waddr,
    input  logic               we,
    input  dualLanePkg::word   wdata,
    output dualLanePkg::word   rdata1,
    output dualLanePkg::word   rdata2
);
    import dualLanePkg::*;

    word regs [NumRegs];  // entry 0 is never written

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 first, then same-cycle write bypass
    assign rdata1 = (raddr1 == '0) ? '0 : (we && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (we && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// ==== lane/lanePipeline.sv ====
`timescale 1ns/1ns
`default_nettype none

module lanePipeline (
    input  logic                       clk,
    input  logic                       reset,
    output dualLanePkg::imemAddr       instrAddr,
    input  dualLanePkg::word           instr,
    output dualLanePkg::laneHazardIn   hzIn,
    input  dualLanePkg::laneHazardCtrl hzCtrl,
    output dualLanePkg::memReq         memOut,
    input  logic                       memWait,
    input  dualLanePkg::word           readData,
    output dualLanePkg::retireInfo     retire
);
    import dualLanePkg::*;

    typedef struct packed {
        word pc;
        word instr;
    } fdStage;

    typedef struct packed {
        word      pc;
        decodedOp op;
        word      rd1;
        word      rd2;
    } deStage;

    typedef struct packed {
        logic     regWrite;
        logic     memWrite;
        resultSrc resSrc;
        regIdx    rd;
        word      aluResult;  // also the data address
        word      storeData;
        word      pcPlus4;
    } emStage;

    typedef struct packed {
        logic     regWrite;
        resultSrc resSrc;
        regIdx    rd;
        word      aluResult;
        word      loadData;
        word      pcPlus4;
    } mwStage;

    word      pcF;
    logic     validD, validE, validM, validW;
    fdStage   fdR;
    deStage   deR;
    emStage   emR;
    mwStage   mwR;
    decodedOp opD;
    word      rd1D, rd2D;
    word      srcA, srcB, aluB, aluResult, target, pcPlus4E, fwdM, resultW;
    pcSel     pcSelE;
    logic     regWriteM, regWriteW;

    // fetch
    assign instrAddr = pcF[$bits(imemAddr)+1:2];  // byte pc to word index

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= '0;
        end else if (!hzCtrl.stallLane) begin
            if (pcSelE != pcSeq) pcF <= target;  // redirect beats load-use
            else if (!hzCtrl.stallF) pcF <= pcF + 32'd4;
        end
    end

    // decode
    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
        end else if (!hzCtrl.stallLane) begin
            if (hzCtrl.flushD) validD <= 1'b0;
            else if (!hzCtrl.stallD) validD <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!hzCtrl.stallLane && !hzCtrl.stallD) fdR <= '{pc: pcF, instr: instr};
    end

    instrDecoder decoder (
        .instr(fdR.instr),
        .op   (opD)
    );

    regFile regs (
        .clk   (clk),
        .reset (reset),
        .raddr1(opD.rs1),
        .raddr2(opD.rs2),
        .waddr (mwR.rd),
        .we    (regWriteW),
        .wdata (resultW),
        .rdata1(rd1D),
        .rdata2(rd2D)
    );

    // execute
    always_ff @(posedge clk) begin
        if (reset) validE <= 1'b0;
        else if (!hzCtrl.stallLane) validE <= validD && !hzCtrl.flushE;
    end

    always_ff @(posedge clk) begin
        if (hzCtrl.stallLane) begin
            deR.rd1 <= srcA;  // capture forwarded operands, w drains while held
            deR.rd2 <= srcB;
        end else begin
            deR <= '{pc: fdR.pc, op: opD, rd1: rd1D, rd2: rd2D};
        end
    end

    always_comb begin
        case (hzCtrl.forwardA)
            fwdMem:  srcA = fwdM;
            fwdWb:   srcA = resultW;
            default: srcA = deR.rd1;
        endcase
        case (hzCtrl.forwardB)
            fwdMem:  srcB = fwdM;
            fwdWb:   srcB = resultW;
            default: srcB = deR.rd2;
        endcase
    end

    assign aluB = deR.op.aluSrcImm ? deR.op.imm : srcB;

    always_comb begin
        case (deR.op.aluCtl)
            aluSub:  aluResult = srcA - aluB;
            aluAnd:  aluResult = srcA & aluB;
            aluOr:   aluResult = srcA | aluB;
            default: aluResult = srcA + aluB;
        endcase
    end

    assign target   = deR.pc + deR.op.imm;  // beq and jal are both pc relative
    assign pcPlus4E = deR.pc + 32'd4;

    always_comb begin
        if (!validE) pcSelE = pcSeq;
        else if (deR.op.isJump) pcSelE = pcJump;
        else if (deR.op.isBranch && srcA == srcB) pcSelE = pcBranch;  // beq taken
        else pcSelE = pcSeq;
    end

    // memory
    always_ff @(posedge clk) begin
        if (reset) validM <= 1'b0;
        else if (!hzCtrl.stallLane) validM <= validE;
    end

    always_ff @(posedge clk) begin
        if (!hzCtrl.stallLane) begin
            emR <= '{regWrite: deR.op.regWrite, memWrite: deR.op.memWrite,
                     resSrc: deR.op.resSrc, rd: deR.op.rd, aluResult: aluResult,
                     storeData: srcB, pcPlus4: pcPlus4E};
        end
    end

    assign memOut = '{valid: validM && (emR.memWrite || emR.resSrc == srcMem),
                      write: emR.memWrite,
                      addr:  emR.aluResult[$bits(dmemAddr)+1:2],
                      wdata: emR.storeData};

    assign regWriteM = validM && emR.regWrite;
    assign fwdM      = (emR.resSrc == srcPcPlus4) ? emR.pcPlus4 : emR.aluResult;  // jal link

    // writeback
    always_ff @(posedge clk) begin
        if (reset) validW <= 1'b0;
        else validW <= validM && !hzCtrl.stallLane;  // bubble while m is held
    end

    always_ff @(posedge clk) begin
        mwR <= '{regWrite: emR.regWrite, resSrc: emR.resSrc, rd: emR.rd,
                 aluResult: emR.aluResult, loadData: readData, pcPlus4: emR.pcPlus4};
    end

    always_comb begin
        case (mwR.resSrc)
            srcMem:     resultW = mwR.loadData;
            srcPcPlus4: resultW = mwR.pcPlus4;
            default:    resultW = mwR.aluResult;
        endcase
    end

    assign regWriteW = validW && mwR.regWrite;
    assign retire    = '{valid: regWriteW && mwR.rd != '0, rd: mwR.rd, value: resultW};

    assign hzIn = '{rs1D: opD.rs1, rs2D: opD.rs2,
                    rs1E: deR.op.rs1, rs2E: deR.op.rs2, rdE: deR.op.rd,
                    rdM: emR.rd, rdW: mwR.rd,
                    regWriteM: regWriteM, regWriteW: regWriteW,
                    resultSrcE: validE ? deR.op.resSrc : srcAlu,  // bubble is no load
                    pcSelE: pcSelE, memWait: memWait};

endmodule

`default_nettype wire

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  dualLanePkg::laneHazardIn   hz1,
    input  dualLanePkg::laneHazardIn   hz2,
    output dualLanePkg::laneHazardCtrl ctrl1,
    output dualLanePkg::laneHazardCtrl ctrl2
);
    import dualLanePkg::*;

    // newest producer wins, x0 never forwards
    function automatic forwardSel fwdFor(regIdx rsE, laneHazardIn hz);
        if (rsE == '0) return fwdNone;
        if (hz.regWriteM && rsE == hz.rdM) return fwdMem;
        if (hz.regWriteW && rsE == hz.rdW) return fwdWb;
        return fwdNone;
    endfunction

    function automatic laneHazardCtrl laneCtrl(laneHazardIn hz);
        laneHazardCtrl c;
        logic          loadUse;
        c          = '0;
        c.forwardA = fwdFor(hz.rs1E, hz);  // forwarding holds even under a lane stall
        c.forwardB = fwdFor(hz.rs2E, hz);
        loadUse    = hz.resultSrcE == srcMem && hz.rdE != '0 &&
                     (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);
        if (hz.memWait) begin
            c.stallLane = 1'b1;  // execute is frozen, nothing else applies
        end else if (hz.pcSelE != pcSeq) begin
            c.flushD = 1'b1;     // drop the two wrong-path instructions
            c.flushE = 1'b1;
        end else if (loadUse) begin
            c.stallF = 1'b1;
            c.stallD = 1'b1;
            c.flushE = 1'b1;     // bubble behind the load
        end
        return c;
    endfunction

    // lanes are independent, same rules on each
    assign ctrl1 = laneCtrl(hz1);
    assign ctrl2 = laneCtrl(hz2);

endmodule

`default_nettype wire

// ==== design/memArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memArbiter (
    input  logic               clk,
    input  logic               reset,
    input  dualLanePkg::memReq req1,
    input  dualLanePkg::memReq req2,
    output logic               memWait1,
    output logic               memWait2,
    output dualLanePkg::memReq grantedReq
);
    import dualLanePkg::*;

    logic lane2WonLast;  // winner of the most recent conflict
    logic conflict;
    logic grant2;

    assign conflict = req1.valid && req2.valid;
    assign grant2   = req2.valid && (!req1.valid || !lane2WonLast);  // alone, or lane 1 won last

    always_ff @(posedge clk) begin
        if (reset) lane2WonLast <= 1'b1;  // so lane 1 goes first
        else if (conflict) lane2WonLast <= grant2;
    end

    assign memWait1   = req1.valid && grant2;
    assign memWait2   = req2.valid && !grant2;
    assign grantedReq = grant2 ? req2 : req1;  // idle passes req1 with valid low

endmodule

`default_nettype wire

// ==== design/dataMemory.sv ====
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
    input  logic               clk,
    input  dualLanePkg::memReq req,
    output dualLanePkg::word   readData
);
    import dualLanePkg::*;

    word mem [DataWords];

    initial begin
        for (int i = 0; i < DataWords; i++) begin
            mem[i] = '0;  // plain ram contents at power up
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid && req.write) mem[req.addr] <= req.wdata;
    end

    assign readData = mem[req.addr];  // async read, shared by both lanes

endmodule

`default_nettype wire

// ==== design/dualLaneCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualLaneCore (
    input  logic                   clk,
    input  logic                   reset,
    output dualLanePkg::imemAddr   instrAddr1,
    output dualLanePkg::imemAddr   instrAddr2,
    input  dualLanePkg::word       instr1,
    input  dualLanePkg::word       instr2,
    output dualLanePkg::retireInfo retire1,
    output dualLanePkg::retireInfo retire2
);
    import dualLanePkg::*;

    laneHazardIn   hz1, hz2;
    laneHazardCtrl ctrl1, ctrl2;
    memReq         req1, req2, grantedReq;
    logic          memWait1, memWait2;
    word           readData;  // one read bus, both lanes

    lanePipeline lane1 (
        .clk      (clk),
        .reset    (reset),
        .instrAddr(instrAddr1),
        .instr    (instr1),
        .hzIn     (hz1),
        .hzCtrl   (ctrl1),
        .memOut   (req1),
        .memWait  (memWait1),
        .readData (readData),
        .retire   (retire1)
    );

    lanePipeline lane2 (
        .clk      (clk),
        .reset    (reset),
        .instrAddr(instrAddr2),
        .instr    (instr2),
        .hzIn     (hz2),
        .hzCtrl   (ctrl2),
        .memOut   (req2),
        .memWait  (memWait2),
        .readData (readData),
        .retire   (retire2)
    );

    hazardUnit hazards (
        .hz1  (hz1),
        .hz2  (hz2),
        .ctrl1(ctrl1),
        .ctrl2(ctrl2)
    );

    memArbiter arbiter (
        .clk       (clk),
        .reset     (reset),
        .req1      (req1),
        .req2      (req2),
        .memWait1  (memWait1),
        .memWait2  (memWait2),
        .grantedReq(grantedReq)
    );

    dataMemory dmem (
        .clk     (clk),
        .req     (grantedReq),
        .readData(readData)
    );

endmodule

`default_nettype wire

// ==== verif/dualLaneCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dualLaneCoreTb;
    import dualLanePkg::*;

    localparam int ClkPeriod   = 100;
    localparam int DriveDelay  = 5;   // ns after the rising edge
    localparam int ResetCycles = 3;
    localparam int DrainCycles = 10;  // catches stray retires after the last record

    logic      clk;
    logic      reset;
    imemAddr   instrAddr1, instrAddr2;
    word       instr1, instr2;
    retireInfo retire1, retire2;

    word       imem1 [ImemWords];  // lane 1 program image
    word       imem2 [ImemWords];  // lane 2 program image
    retireInfo expected1 [$];      // retire records still to come, in order
    retireInfo expected2 [$];
    int        remaining1, remaining2;
    int        instrCount;         // sizes the watchdog
    logic      traceLoaded;

    dualLaneCore dut (
        .clk       (clk),
        .reset     (reset),
        .instrAddr1(instrAddr1),
        .instrAddr2(instrAddr2),
        .instr1    (instr1),
        .instr2    (instr2),
        .retire1   (retire1),
        .retire2   (retire2)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input word actual, input word expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // next record of the lane against what came out of writeback
    task automatic matchRetire(input int lane, input retireInfo got);
        retireInfo want;
        if ((lane == 1 && expected1.size() == 0) || (lane == 2 && expected2.size() == 0)) begin
            $display("lane %0d retired x%0d = 0x%08h after all its expected records were seen",
                     lane, got.rd, got.value);
            $display("Test failed");
            $fatal(1);
        end else begin
            if (lane == 1) want = expected1.pop_front();
            else want = expected2.pop_front();
            checkValue($sformatf("retire%0d.rd", lane), word'(got.rd), word'(want.rd));
            checkValue($sformatf("retire%0d.value", lane), got.value, want.value);
            if (lane == 1) remaining1--;
            else remaining2--;
        end
    endtask

    // I lines fill the programs, W lines queue the expected retires
    task automatic readTrace(output int badLines);
        int            fd;
        int            n;
        int            lane;
        int            idx;
        logic [31:0]   value;
        logic [7:0]    tag;     // first character of the line tag
        logic [2047:0] rest;
        logic          done;
        retireInfo     rec;
        badLines = 0;
        done     = 1'b0;
        fd       = $fopen("verif/dualLaneTrace.txt", "r");
        if (fd == 0) begin
            badLines = 1;
            $display("could not open the trace file verif/dualLaneTrace.txt");
        end else begin
            while (!done) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    done = 1'b1;            // end of file
                end else if (tag == "#") begin
                    n = $fgets(rest, fd);   // comment line
                end else begin
                    n = $fscanf(fd, "%d %d %h", lane, idx, value);
                    if (n != 3 || lane < 1 || lane > 2 || idx < 0) begin
                        badLines++;
                    end else if (tag == "I" && idx < ImemWords) begin
                        if (lane == 1) imem1[idx] = value;
                        else imem2[idx] = value;
                        instrCount++;
                    end else if (tag == "W" && idx < NumRegs) begin
                        rec.valid = 1'b1;
                        rec.rd    = regIdx'(idx);
                        rec.value = value;
                        if (lane == 1) expected1.push_back(rec);
                        else expected2.push_back(rec);
                    end else begin
                        badLines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // instruction memories answer the fetch address of the current cycle
    always @(posedge clk) begin
        #DriveDelay;
        instr1 = imem1[instrAddr1];
        instr2 = imem2[instrAddr2];
    end

    always @(posedge clk) begin
        if (!reset && retire1.valid) matchRetire(1, retire1);
        if (!reset && retire2.valid) matchRetire(2, retire2);
    end

    initial begin : mainSeq
        int badLines;
        reset       = 1'b1;
        instr1      = '0;
        instr2      = '0;
        traceLoaded = 1'b0;
        instrCount  = 0;
        for (int i = 0; i < ImemWords; i++) begin
            imem1[i] = '0;  // unused words decode as no-ops
            imem2[i] = '0;
        end
        readTrace(badLines);
        remaining1  = expected1.size();
        remaining2  = expected2.size();
        traceLoaded = 1'b1;
        if (badLines != 0 || remaining1 == 0 || remaining2 == 0) begin
            $display("trace file is missing or malformed, %0d bad lines", badLines);
            $display("Test failed");
            $fatal(1);
        end else begin
            repeat (ResetCycles) @(posedge clk);
            #DriveDelay;
            reset = 1'b0;
            wait (remaining1 == 0 && remaining2 == 0);
            repeat (DrainCycles) @(negedge clk);
            $display("Test passed");
            $finish;
        end
    end

    initial begin : watchdog
        int limit;
        wait (traceLoaded === 1'b1);
        limit = (instrCount + 20) * 10;  // generous per-instruction budget
        repeat (limit) @(posedge clk);
        $display("timeout: the retire streams did not complete within %0d cycles", limit);
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== verif/dualLaneTrace.txt ====
# I lane addr data    instruction word at a word index of the lane program
# W lane rd value     next expected retire of the lane, rd in decimal, value in hex
# lane 1 alu ops, forwarding, x0 write, stores, load-use
I 1 0 00500093
I 1 1 00C00113
I 1 2 002081B3
I 1 3 40118233
I 1 4 003262B3
I 1 5 0012F333
I 1 6 00708013
I 1 7 00502023
I 1 8 00602223
I 1 9 00002383
I 1 10 00138433
I 1 11 00402483
I 1 12 0000006F
# lane 2 branches, jal link, stores and loads at words 16 and 17
I 2 0 00300093
I 2 1 00008463
I 2 2 00408113
I 2 3 00210663
I 2 4 05500193
I 2 5 06600193
I 2 6 00C0056F
I 2 7 07700213
I 2 8 08800213
I 2 9 04202023
I 2 10 04A02223
I 2 11 04002283
I 2 12 04402303
I 2 13 0000006F
# lane 1 retires
W 1 1 00000005
W 1 2 0000000c
W 1 3 00000011
W 1 4 0000000c
W 1 5 0000001d
W 1 6 00000005
W 1 7 0000001d
W 1 8 00000022
W 1 9 00000005
# lane 2 retires
W 2 1 00000003
W 2 2 00000007
W 2 10 0000001c
W 2 5 00000007
W 2 6 0000001c

// ==== src.f ====
common/dualLanePkg.sv
lane/instrDecoder.sv
lane/regFile.sv
lane/lanePipeline.sv
design/hazardUnit.sv
design/memArbiter.sv
design/dataMemory.sv
design/dualLaneCore.sv
verif/dualLaneCoreTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module dualLaneCoreTb -f src.f -o simv &&
./obj_dir/simv || exit 1
